/* sources.f */
+incdir+test
common/mmu_pkg.sv
rtl/pt_mem.sv
ptw/ptw_fault_check.sv
ptw/ptw_walker.sv
rtl/mmu_walk_top.sv
test/mmu_walk_tb.sv

/* run.sh */
#!/bin/sh
# build the walker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mmu_walk_tb -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vmmu_walk_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* test/mmu_walk_model.svh */
`ifndef MMU_WALK_MODEL_SVH
`define MMU_WALK_MODEL_SVH

logic [DWORD_W-1:0]   model_mem [2**PT_MEM_LG];   // mirror of every write to the DUT
logic [PT_MEM_LG-1:0] path_idx [LEVELS];          // words read by the last modeled walk

// physical address bits 3 to 14 pick the dword
function automatic logic [PT_MEM_LG-1:0] pte_index(input logic [PPN_W-1:0] ppn,
                                                   input logic [VADDR_W-1:0] va,
                                                   input int lvl);
  logic [PADDR_W-1:0] pa;
  pa = {ppn, va[PAGE_OFFSET_W + lvl * PAGE_IDX_W +: PAGE_IDX_W], {PTE_BYTES_LG{1'b0}}};
  return pa[PTE_BYTES_LG +: PT_MEM_LG];
endfunction

function automatic logic on_path(input logic [PT_MEM_LG-1:0] idx);
  logic hit;
  hit = 1'b0;
  for (int i = 0; i < LEVELS; i++) begin
    hit = hit | (idx == path_idx[i]);
  end
  return hit;
endfunction

function automatic ptw_fill_pkt_s model_walk(input ptw_miss_pkt_s m, output int end_level);
  ptw_fill_pkt_s    f;
  sv39_pte_s        pte;
  logic [PPN_W-1:0] ppn;
  logic             leaf, common, i_f, l_f, s_f, fault;
  int               lvl;
  ppn = m.base_ppn;
  for (int i = 0; i < LEVELS; i++) begin
    path_idx[i] = pte_index(ppn, m.vaddr, LEVELS - 1);
  end
  for (lvl = LEVELS - 1; lvl >= 0; lvl--) begin
    path_idx[lvl] = pte_index(ppn, m.vaddr, lvl);
    pte    = sv39_pte_s'(model_mem[path_idx[lvl]]);
    leaf   = pte.r | pte.w | pte.x;
    common = !pte.v || (pte.w && !pte.r) || (lvl == 0 && !leaf);
    if (leaf) begin
      common |= pte.u && (m.priv_mode == PRIV_S) && (m.instr_miss_v || !m.mstatus_sum);
      common |= !pte.u && (m.priv_mode == PRIV_U);
      common |= (pte.ppn & ((PPN_W'(1) << (lvl * PAGE_IDX_W)) - PPN_W'(1))) != '0;
      common |= !pte.a || (m.store_miss_v && !pte.d);
    end
    i_f = m.instr_miss_v && (common || (leaf && !pte.x));
    l_f = m.load_miss_v && (common || (leaf && !(pte.r || (pte.x && m.mstatus_mxr))));
    s_f = m.store_miss_v && (common || (leaf && !pte.w));
    if (leaf || i_f || l_f || s_f) break;
    ppn = pte.ppn;   // next table
  end
  fault = i_f | l_f | s_f;
  f = '0;
  f.itlb_fill_v        = m.instr_miss_v & ~fault;
  f.dtlb_fill_v        = (m.load_miss_v | m.store_miss_v) & ~fault;
  f.instr_page_fault_v = i_f;
  f.load_page_fault_v  = l_f;
  f.store_page_fault_v = s_f;
  f.vaddr              = m.vaddr;
  f.entry.ptag         = pte.ppn;
  for (int i = 0; i < lvl; i++) begin   // superpage takes low slices from the vpn
    f.entry.ptag[i * PAGE_IDX_W +: PAGE_IDX_W] =
      m.vaddr[PAGE_OFFSET_W + i * PAGE_IDX_W +: PAGE_IDX_W];
  end
  f.entry.level = LEVEL_W'(lvl);
  f.entry.a     = pte.a;
  f.entry.d     = pte.d;
  f.entry.u     = pte.u;
  f.entry.x     = pte.x;
  f.entry.w     = pte.w;
  f.entry.r     = pte.r;
  end_level = lvl;
  return f;
endfunction

`endif

/* test/mmu_walk_tb.sv */
`timescale 1ns/1ps

module mmu_walk_tb
  import mmu_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int WALKS       = 400;
  localparam int LOAD_CYCLES = 2**PT_MEM_LG + WALKS * (LEVELS + 2);
  localparam int WATCHDOG_NS = (WALKS * 64 + LOAD_CYCLES) * CLK_PERIOD;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic                 miss_v_i;
  ptw_miss_pkt_s        miss_pkt_i;
  logic                 busy_o;
  logic                 fill_v_o;
  ptw_fill_pkt_s        fill_pkt_o;
  logic                 mem_w_v_i;
  logic [PT_MEM_LG-1:0] mem_w_addr_i;
  logic [DWORD_W-1:0]   mem_w_data_i;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  mmu_walk_top DUT (.*);

  `include "mmu_walk_model.svh"

  task automatic fail_now();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_fill(input ptw_fill_pkt_s expected, input ptw_fill_pkt_s actual);
    if (actual !== expected) begin
      $display("Error: time %0t fill_pkt_o expected %h actual %h", $time, expected, actual);
      fail_now();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: time %0t %s expected %b actual %b", $time, name, expected, actual);
      fail_now();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Error: time %0t %s expected %0d actual %0d", $time, name, expected, actual);
      fail_now();
    end
  endtask

  function automatic logic [DWORD_W-1:0] fill_word(input logic [PT_MEM_LG-1:0] idx);
    return {idx, ~idx, idx ^ 12'ha5c, idx ^ 12'h3c9, 4'h9, idx};
  endfunction

  function automatic ptw_miss_pkt_s random_miss();
    ptw_miss_pkt_s m;
    int unsigned   kind;
    m = '0;
    kind = $urandom_range(2);
    m.vaddr        = VADDR_W'({$urandom, $urandom});
    m.base_ppn     = PPN_W'({$urandom, $urandom});
    m.instr_miss_v = (kind == 0);
    m.load_miss_v  = (kind == 1);
    m.store_miss_v = (kind == 2);
    case ($urandom_range(3))
      0:       m.priv_mode = PRIV_U;
      3:       m.priv_mode = PRIV_M;
      default: m.priv_mode = PRIV_S;
    endcase
    m.mstatus_sum = 1'($urandom_range(1));
    m.mstatus_mxr = 1'($urandom_range(1));
    return m;
  endfunction

  // mostly valid, with the permission the access needs
  function automatic sv39_pte_s random_pte(input logic leaf, input int lvl,
                                           input ptw_miss_pkt_s m);
    sv39_pte_s   p;
    logic [31:0] r;
    r = $urandom;
    p = sv39_pte_s'({$urandom, $urandom});
    p.v = |r[3:0];
    p.a = |r[6:4];
    p.d = |r[9:7];
    if (leaf) begin
      p.x = r[10] | (m.instr_miss_v & |r[12:11]);
      p.r = r[13] | (~m.instr_miss_v & |r[15:14]);
      p.w = r[16] | (m.store_miss_v & |r[18:17]);
      p.r = p.r | ~(p.x | p.w);
      p.u = (m.priv_mode == PRIV_U) ^ (r[21:19] == 3'b000);
      if (r[23:22] != 2'b00) begin
        p.ppn = p.ppn & ~((PPN_W'(1) << (lvl * PAGE_IDX_W)) - PPN_W'(1));
      end
    end else if (r[27:24] != 4'h0) begin
      p.r = 1'b0;
      p.w = 1'b0;
      p.x = 1'b0;
    end
    return p;
  endfunction

  task automatic drive_write(input logic [PT_MEM_LG-1:0] idx, input logic [DWORD_W-1:0] data);
    mem_w_v_i     <= 1'b1;
    mem_w_addr_i  <= idx;
    mem_w_data_i  <= data;
    model_mem[idx] = data;
  endtask

  // random write to a word the walk does not read
  task automatic drive_noise(input logic noisy, inout logic wrote);
    logic [PT_MEM_LG-1:0] idx;
    idx = PT_MEM_LG'($urandom);
    if (noisy && ($urandom_range(3) == 0) && !on_path(idx)) begin
      drive_write(idx, {$urandom, $urandom});
      wrote = 1'b1;
    end else begin
      mem_w_v_i <= 1'b0;
    end
  endtask

  task automatic write_word(input logic [PT_MEM_LG-1:0] idx, input logic [DWORD_W-1:0] data);
    @(posedge clk_i);
    drive_write(idx, data);
  endtask

  task automatic load_memory();
    for (int i = 0; i < 2**PT_MEM_LG; i++) begin
      write_word(PT_MEM_LG'(i), fill_word(PT_MEM_LG'(i)));
    end
    @(posedge clk_i);
    mem_w_v_i <= 1'b0;
  endtask

  task automatic build_path(input ptw_miss_pkt_s m);
    logic [PPN_W-1:0] ppn;
    sv39_pte_s        pte;
    int               leaf_lvl;
    ppn      = m.base_ppn;
    leaf_lvl = $urandom_range(LEVELS - 1);
    for (int lvl = LEVELS - 1; lvl >= leaf_lvl; lvl--) begin
      pte = random_pte(lvl == leaf_lvl, lvl, m);
      write_word(pte_index(ppn, m.vaddr, lvl), pte);
      ppn = pte.ppn;
    end
    @(posedge clk_i);
    mem_w_v_i <= 1'b0;
  endtask

  task automatic offer_empty_miss();
    ptw_miss_pkt_s m;
    m = random_miss();
    m.instr_miss_v = 1'b0;
    m.load_miss_v  = 1'b0;
    m.store_miss_v = 1'b0;
    @(posedge clk_i);
    miss_v_i   <= 1'b1;
    miss_pkt_i <= m;
    @(posedge clk_i);
    miss_v_i <= 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      check_bit("busy_o", 1'b0, busy_o);
    end
  endtask

  task automatic run_walk(input ptw_miss_pkt_s m, input logic noisy);
    ptw_fill_pkt_s        expected;
    int                   end_level;
    int                   cycles;
    logic                 spurious;
    logic                 wrote;
    expected = model_walk(m, end_level);
    spurious = ($urandom_range(3) == 0);
    wrote    = 1'b0;
    cycles   = 0;
    @(posedge clk_i);
    miss_v_i   <= 1'b1;
    miss_pkt_i <= m;
    drive_noise(noisy, wrote);
    do begin
      @(posedge clk_i);
      miss_v_i <= spurious && (cycles == 1);   // offered while busy
      if (cycles == 1) begin
        miss_pkt_i <= random_miss();
      end
      drive_noise(noisy, wrote);
      @(negedge clk_i);
      cycles++;
      if (cycles == 1) begin
        check_bit("busy_o", 1'b1, busy_o);
      end
    end while (!fill_v_o);
    check_fill(expected, fill_pkt_o);
    // ordered, then send, receive and check per level, writeback on the next
    if (!wrote) begin
      check_count("fill_v_o latency", 2 + 3 * (LEVELS - end_level), cycles);
    end
    @(posedge clk_i);
    mem_w_v_i <= 1'b0;
    miss_v_i  <= 1'b0;
    @(negedge clk_i);
    check_bit("fill_v_o", 1'b0, fill_v_o);
    check_bit("busy_o", 1'b0, busy_o);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the walks did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $fatal(1);
  end

  initial begin
    ptw_miss_pkt_s m;
    void'($urandom(32'hf6bb427e));
    reset_i      = 1'b1;
    miss_v_i     = 1'b0;
    miss_pkt_i   = '0;
    mem_w_v_i    = 1'b0;
    mem_w_addr_i = '0;
    mem_w_data_i = '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("fill_v_o", 1'b0, fill_v_o);
    load_memory();
    offer_empty_miss();
    for (int n = 0; n < WALKS; n++) begin
      m = random_miss();
      build_path(m);
      run_walk(m, 1'($urandom_range(1)));
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* rtl/mmu_walk_top.sv */
`timescale 1ns/1ps

module mmu_walk_top
  import mmu_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 miss_v_i,
  input  ptw_miss_pkt_s        miss_pkt_i,
  output logic                 busy_o,
  output logic                 fill_v_o,
  output ptw_fill_pkt_s        fill_pkt_o,
  input  logic                 mem_w_v_i,
  input  logic [PT_MEM_LG-1:0] mem_w_addr_i,
  input  logic [DWORD_W-1:0]   mem_w_data_i
);

  logic        rd_v;
  mem_rd_req_s rd_req;
  logic        rd_ready;
  logic        ordered;
  logic        rsp_v;
  sv39_pte_s   rsp_data;

  ptw_walker u_walker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .miss_v_i   (miss_v_i),
    .miss_pkt_i (miss_pkt_i),
    .busy_o     (busy_o),
    .rd_v_o     (rd_v),
    .rd_req_o   (rd_req),
    .rd_ready_i (rd_ready),
    .ordered_i  (ordered),
    .rsp_v_i    (rsp_v),
    .rsp_pte_i  (rsp_data),
    .fill_v_o   (fill_v_o),
    .fill_pkt_o (fill_pkt_o)
  );

  pt_mem u_pt_mem (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .w_v_i      (mem_w_v_i),
    .w_addr_i   (mem_w_addr_i),
    .w_data_i   (mem_w_data_i),
    .rd_v_i     (rd_v),
    .rd_req_i   (rd_req),
    .rd_ready_o (rd_ready),
    .ordered_o  (ordered),
    .rsp_v_o    (rsp_v),
    .rsp_pte_o  (rsp_data)
  );

endmodule

/* ptw/ptw_walker.sv */
`timescale 1ns/1ps

module ptw_walker
  import mmu_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          miss_v_i,
  input  ptw_miss_pkt_s miss_pkt_i,
  output logic          busy_o,
  output logic          rd_v_o,
  output mem_rd_req_s   rd_req_o,
  input  logic          rd_ready_i,
  input  logic          ordered_i,
  input  logic          rsp_v_i,
  input  sv39_pte_s     rsp_pte_i,
  output logic          fill_v_o,
  output ptw_fill_pkt_s fill_pkt_o
);

  typedef enum logic [2:0] {
    e_idle,
    e_ordered,
    e_send,
    e_recv,
    e_check,
    e_writeback
  } state_e;

  state_e                              state_r, state_n;
  logic                                start;
  logic                                is_recv, is_check, is_wb;
  logic [LEVEL_W-1:0]                  level_r;
  logic [PPN_W-1:0]                    ppn_r;
  ptw_miss_pkt_s                       miss_r;
  sv39_pte_s                           pte_r;
  pte_check_s                          check;
  logic                                fault_v;
  logic [LEVELS-1:0][PAGE_IDX_W-1:0]   vpn_slice;
  logic [PPN_W-1:0]                    leaf_ptag;

  assign is_recv  = (state_r == e_recv);
  assign is_check = (state_r == e_check);
  assign is_wb    = (state_r == e_writeback);

  assign start = (state_r == e_idle) & miss_v_i
               & (miss_pkt_i.instr_miss_v | miss_pkt_i.load_miss_v | miss_pkt_i.store_miss_v);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      level_r <= '0;
    end else begin
      state_r <= state_n;
      if (start) begin
        level_r <= LEVEL_W'(LEVELS-1);
      end else if (is_check & check.descend) begin
        level_r <= level_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      miss_r <= miss_pkt_i;
      ppn_r  <= miss_pkt_i.base_ppn;
    end else if (is_check & check.descend) begin
      ppn_r  <= pte_r.ppn;   // next table
    end
    if (is_recv & rsp_v_i) begin
      pte_r <= rsp_pte_i;
    end
  end

  // a dropped response goes back through ordered and replays the read
  always_comb begin
    case (state_r)
      e_idle:      state_n = start ? e_ordered : e_idle;
      e_ordered:   state_n = ordered_i ? e_send : e_ordered;
      e_send:      state_n = rd_ready_i ? e_recv : e_send;
      e_recv:      state_n = rsp_v_i ? e_check : e_ordered;
      e_check:     state_n = check.descend ? e_send : e_writeback;
      default:     state_n = e_idle;
    endcase
  end

  ptw_fault_check u_fault_check (
    .pte_i   (pte_r),
    .miss_i  (miss_r),
    .level_i (level_r),
    .check_o (check)
  );

  assign vpn_slice = miss_r.vaddr[PAGE_OFFSET_W +: VPN_W];

  assign rd_v_o         = (state_r == e_send);
  assign rd_req_o.paddr = {ppn_r, vpn_slice[level_r], {PTE_BYTES_LG{1'b0}}};
  assign rd_req_o.ptag  = ppn_r;

  for (genvar i = 0; i < LEVELS-1; i++) begin : g_ptag
    assign leaf_ptag[i*PAGE_IDX_W +: PAGE_IDX_W] =
      (level_r > i) ? vpn_slice[i] : pte_r.ppn[i*PAGE_IDX_W +: PAGE_IDX_W];
  end
  assign leaf_ptag[PPN_W-1:(LEVELS-1)*PAGE_IDX_W] =
    pte_r.ppn[PPN_W-1:(LEVELS-1)*PAGE_IDX_W];

  assign fault_v = check.instr_fault | check.load_fault | check.store_fault;

  assign busy_o   = (state_r != e_idle);
  assign fill_v_o = is_wb;

  always_comb begin
    fill_pkt_o.itlb_fill_v        = is_wb & miss_r.instr_miss_v & ~fault_v;
    fill_pkt_o.dtlb_fill_v        = is_wb & (miss_r.load_miss_v | miss_r.store_miss_v)
                                  & ~fault_v;
    fill_pkt_o.instr_page_fault_v = is_wb & check.instr_fault;
    fill_pkt_o.load_page_fault_v  = is_wb & check.load_fault;
    fill_pkt_o.store_page_fault_v = is_wb & check.store_fault;
    fill_pkt_o.vaddr              = miss_r.vaddr;
    fill_pkt_o.entry.ptag         = leaf_ptag;
    fill_pkt_o.entry.level        = level_r;
    fill_pkt_o.entry.a            = pte_r.a;
    fill_pkt_o.entry.d            = pte_r.d;
    fill_pkt_o.entry.u            = pte_r.u;
    fill_pkt_o.entry.x            = pte_r.x;
    fill_pkt_o.entry.w            = pte_r.w;
    fill_pkt_o.entry.r            = pte_r.r;
  end

endmodule

/* ptw/ptw_fault_check.sv */
`timescale 1ns/1ps

module ptw_fault_check
  import mmu_pkg::*;
(
  input  sv39_pte_s          pte_i,
  input  ptw_miss_pkt_s      miss_i,
  input  logic [LEVEL_W-1:0] level_i,
  output pte_check_s         check_o
);

  logic                  is_leaf;
  logic                  pte_invalid;
  logic                  leaf_not_found;
  logic                  priv_fault;
  logic                  misaligned;
  logic                  ad_fault;
  logic                  common_fault;
  logic                  instr_fault;
  logic                  load_fault;
  logic                  store_fault;
  logic [LEVELS-2:0]     slice_nz;

  assign is_leaf = pte_i.r | pte_i.w | pte_i.x;

  assign pte_invalid    = ~pte_i.v | (pte_i.w & ~pte_i.r);
  assign leaf_not_found = (level_i == '0) & ~is_leaf;

  // S may touch U pages only for data with SUM set
  assign priv_fault = is_leaf &
                      ((pte_i.u & (miss_i.priv_mode == PRIV_S)
                                & (miss_i.instr_miss_v | ~miss_i.mstatus_sum))
                       | (~pte_i.u & (miss_i.priv_mode == PRIV_U)));

  // superpage must have zero ppn below its level
  for (genvar i = 0; i < LEVELS-1; i++) begin : g_align
    assign slice_nz[i] = (level_i > i) & (|pte_i.ppn[i*PAGE_IDX_W +: PAGE_IDX_W]);
  end
  assign misaligned = is_leaf & (|slice_nz);

  assign ad_fault = is_leaf & (~pte_i.a | (miss_i.store_miss_v & ~pte_i.d));

  assign common_fault = pte_invalid | leaf_not_found | priv_fault | misaligned | ad_fault;

  assign instr_fault = miss_i.instr_miss_v &
                       (common_fault | (is_leaf & ~pte_i.x));
  assign load_fault  = miss_i.load_miss_v &
                       (common_fault
                        | (is_leaf & ~(pte_i.r | (pte_i.x & miss_i.mstatus_mxr))));
  assign store_fault = miss_i.store_miss_v &
                       (common_fault | (is_leaf & ~pte_i.w));

  always_comb begin
    check_o.is_leaf     = is_leaf;
    check_o.instr_fault = instr_fault;
    check_o.load_fault  = load_fault;
    check_o.store_fault = store_fault;
    check_o.descend     = ~is_leaf & ~(instr_fault | load_fault | store_fault);
  end

endmodule

/* rtl/pt_mem.sv */
`timescale 1ns/1ps

module pt_mem
  import mmu_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 w_v_i,
  input  logic [PT_MEM_LG-1:0] w_addr_i,
  input  logic [DWORD_W-1:0]   w_data_i,
  input  logic                 rd_v_i,
  input  mem_rd_req_s          rd_req_i,
  output logic                 rd_ready_o,
  output logic                 ordered_o,
  output logic                 rsp_v_o,
  output sv39_pte_s            rsp_pte_o
);

  sv39_pte_s            mem [2**PT_MEM_LG];
  logic                 w_pend_r;
  logic [PT_MEM_LG-1:0] w_addr_r;
  logic [DWORD_W-1:0]   w_data_r;
  logic                 rsp_v_r;
  logic [PT_MEM_LG-1:0] rd_idx_r;

  assign rd_ready_o = ~w_v_i;     // port busy taking a write
  assign ordered_o  = ~w_pend_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_pend_r <= 1'b0;
      rsp_v_r  <= 1'b0;
    end else begin
      w_pend_r <= w_v_i;
      rsp_v_r  <= rd_v_i & rd_ready_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      w_addr_r <= w_addr_i;
      w_data_r <= w_data_i;
    end
    if (w_pend_r) begin
      mem[w_addr_r] <= sv39_pte_s'(w_data_r);
    end
    if (rd_v_i & rd_ready_o) begin
      rd_idx_r <= rd_req_i.paddr[PTE_BYTES_LG +: PT_MEM_LG];
    end
  end

  // a write landing now makes this word stale
  assign rsp_v_o   = rsp_v_r & ~w_pend_r;
  assign rsp_pte_o = mem[rd_idx_r];

endmodule

/* common/mmu_pkg.sv */
package mmu_pkg;

  localparam int VADDR_W       = 39;
  localparam int PPN_W         = 44;
  localparam int PAGE_IDX_W    = 9;
  localparam int LEVELS        = 3;
  localparam int PTE_BYTES_LG  = 3;
  localparam int PT_MEM_LG     = 12;   // memory depth in dwords, log2
  localparam int DWORD_W       = 64;

  localparam int PAGE_OFFSET_W = PAGE_IDX_W + PTE_BYTES_LG;
  localparam int PADDR_W       = PPN_W + PAGE_OFFSET_W;
  localparam int VPN_W         = LEVELS * PAGE_IDX_W;
  localparam int LEVEL_W       = $clog2(LEVELS);

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  typedef struct packed {
    logic [9:0]       reserved;
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } sv39_pte_s;

  typedef struct packed {
    logic [VADDR_W-1:0] vaddr;
    logic [PPN_W-1:0]   base_ppn;    // root table
    logic               instr_miss_v;
    logic               load_miss_v;
    logic               store_miss_v;
    priv_e              priv_mode;
    logic               mstatus_sum;
    logic               mstatus_mxr;
  } ptw_miss_pkt_s;

  typedef struct packed {
    logic [PPN_W-1:0]   ptag;
    logic [LEVEL_W-1:0] level;       // 0 for 4 KiB, 2 for gigapage
    logic               a;
    logic               d;
    logic               u;
    logic               x;
    logic               w;
    logic               r;
  } pte_leaf_s;

  typedef struct packed {
    logic               itlb_fill_v;
    logic               dtlb_fill_v;
    logic               instr_page_fault_v;
    logic               load_page_fault_v;
    logic               store_page_fault_v;
    logic [VADDR_W-1:0] vaddr;
    pte_leaf_s          entry;
  } ptw_fill_pkt_s;

  typedef struct packed {
    logic is_leaf;
    logic descend;
    logic instr_fault;
    logic load_fault;
    logic store_fault;
  } pte_check_s;

  typedef struct packed {
    logic [PADDR_W-1:0] paddr;
    logic [PPN_W-1:0]   ptag;
  } mem_rd_req_s;

endpackage
